/* hdl/dcache_pkg.sv */
// Shared geometry, types and byte-lane helpers for the L1 data cache
// Imported by every cache module and by the testbench
`default_nettype none

package dcache_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int LINE_WORDS = 4;
  localparam int INDEX_W    = 4;
  localparam int OFFSET_W   = 4;
  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
  localparam int LINE_W     = LINE_WORDS * DATA_W;
  localparam int NUM_LINES  = 1 << INDEX_W;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } access_size_e;

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    READ_MISS,
    WRITE_THRU
  } dcache_state_e;

  typedef struct packed {
    logic              write;
    access_size_e      size;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } core_req_t;

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [3:0]        sel;
    logic [DATA_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] dat;
  } wb_rsp_t;

  // Byte lanes touched by an aligned access
  function automatic logic [3:0] byte_sel(access_size_e size, logic [1:0] off);
    logic [3:0] sel;
    case (size)
      SIZE_BYTE: sel = 4'b0001 << off;
      SIZE_HALF: sel = 4'b0011 << {off[1], 1'b0};
      default:   sel = 4'b1111;
    endcase
    return sel;
  endfunction

  // Store data copied onto every lane it may occupy
  function automatic logic [DATA_W-1:0] lane_data(access_size_e size, logic [DATA_W-1:0] wdata);
    logic [DATA_W-1:0] dat;
    case (size)
      SIZE_BYTE: dat = {4{wdata[7:0]}};
      SIZE_HALF: dat = {2{wdata[15:0]}};
      default:   dat = wdata;
    endcase
    return dat;
  endfunction

endpackage

`default_nettype wire

/* hdl/dcache_ctrl.sv */
// Cache controller FSM: lookup, line refill and write-through
// Owns the core handshake and acts as the Wishbone classic master
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic          clk,
  input  logic          rstn,
  input  logic          core_valid,
  input  core_req_t     core_in,
  input  wb_rsp_t       wb_rsp,
  input  logic          hit,
  input  logic          last_beat,
  input  logic [1:0]    beat_addr,
  output logic          core_wait,
  output core_req_t     req_q,
  output wb_req_t       wb_req,
  output dcache_state_e state,
  output logic          tag_rd,
  output logic          tag_fill,
  output logic          data_rd,
  output logic          data_fill_shift,
  output logic          data_fill_write,
  output logic          data_word_write,
  output logic          beat_clear,
  output logic          beat_inc
);

  dcache_state_e next_state;
  logic          bus_done;
  logic          done_q;

  // ========================================
  // State and request registers
  // ========================================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state  <= IDLE;
      done_q <= 1'b0;
    end else begin
      state  <= next_state;
      done_q <= bus_done;
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && core_valid) begin
      req_q <= core_in;
    end
  end

  assign core_wait = (state != IDLE);

  // ========================================
  // Next state, array strobes, Wishbone
  // ========================================
  always_comb begin
    next_state      = state;
    bus_done        = 1'b0;
    tag_rd          = 1'b0;
    tag_fill        = 1'b0;
    data_rd         = 1'b0;
    data_fill_shift = 1'b0;
    data_fill_write = 1'b0;
    data_word_write = 1'b0;
    beat_clear      = 1'b0;
    beat_inc        = 1'b0;
    wb_req          = '0;

    case (state)
      IDLE: begin
        // Arrays read from the live address so the tag is ready in LOOKUP
        tag_rd     = core_valid;
        data_rd    = core_valid;
        beat_clear = 1'b1;
        if (core_valid) begin
          next_state = LOOKUP;
        end
      end

      LOOKUP: begin
        if (done_q) begin
          // Bus part finished, commit line or merged word
          next_state      = IDLE;
          tag_fill        = ~req_q.write;
          data_fill_write = ~req_q.write;
          data_word_write = req_q.write & hit;
        end else if (req_q.write) begin
          next_state = WRITE_THRU;
        end else if (hit) begin
          next_state = IDLE;
        end else begin
          next_state = READ_MISS;
        end
      end

      READ_MISS: begin
        wb_req.cyc      = 1'b1;
        wb_req.stb      = 1'b1;
        wb_req.we       = 1'b0;
        wb_req.adr      = {req_q.addr[ADDR_W-1:OFFSET_W], beat_addr, 2'b00};
        wb_req.sel      = 4'b1111;
        beat_inc        = wb_rsp.ack;
        data_fill_shift = wb_rsp.ack;
        if (wb_rsp.ack && last_beat) begin
          bus_done   = 1'b1;
          next_state = LOOKUP;
        end
      end

      WRITE_THRU: begin
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = {req_q.addr[ADDR_W-1:2], 2'b00};
        wb_req.sel = byte_sel(req_q.size, req_q.addr[1:0]);
        wb_req.dat = lane_data(req_q.size, req_q.wdata);
        beat_inc   = wb_rsp.ack;
        if (wb_rsp.ack) begin
          bus_done   = 1'b1;
          next_state = LOOKUP;
        end
      end

      default: begin
        next_state = IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/dcache_counters.sv */
// Refill beat counter and hit/miss statistics
// Each access is classified on the edge that ends it
`timescale 1ns/1ps
`default_nettype none

module dcache_counters
  import dcache_pkg::*;
(
  input  logic          clk,
  input  logic          rstn,
  input  dcache_state_e state,
  input  logic          hit,
  input  logic          beat_clear,
  input  logic          beat_inc,
  input  logic          is_write,
  output logic [1:0]    beat_addr,
  output logic          last_beat,
  output logic [31:0]   rd_hits,
  output logic [31:0]   wr_hits,
  output logic [31:0]   rd_misses,
  output logic [31:0]   wr_misses
);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      beat_addr <= 2'd0;
    end else if (beat_clear) begin
      beat_addr <= 2'd0;
    end else if (beat_inc) begin
      beat_addr <= beat_addr + 2'd1;
    end
  end

  assign last_beat = &beat_addr;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rd_hits   <= '0;
      wr_hits   <= '0;
      rd_misses <= '0;
      wr_misses <= '0;
    end else begin
      if (state == LOOKUP && hit && !is_write) begin
        rd_hits <= rd_hits + 32'd1;
      end
      if (state == READ_MISS && beat_inc && last_beat) begin
        rd_misses <= rd_misses + 32'd1;
      end
      // Writes end on their single ack
      if (state == WRITE_THRU && beat_inc) begin
        if (hit) begin
          wr_hits <= wr_hits + 32'd1;
        end else begin
          wr_misses <= wr_misses + 32'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/dcache_tag_array.sv */
// Tag store and valid bits with registered read and hit compare
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array
  import dcache_pkg::*;
(
  input  logic               clk,
  input  logic               rstn,
  input  logic [INDEX_W-1:0] index,
  input  logic [TAG_W-1:0]   tag,
  input  logic               rd,
  input  logic               fill,
  output logic               hit
);

  logic [TAG_W-1:0]     tags [NUM_LINES];
  logic [NUM_LINES-1:0] valid;
  logic [TAG_W-1:0]     tag_q;
  logic                 valid_q;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      valid   <= '0;
      valid_q <= 1'b0;
    end else begin
      if (fill) begin
        valid[index] <= 1'b1;
      end
      if (rd) begin
        valid_q <= valid[index];
      end
    end
  end

  // SRAM-like tag storage
  always_ff @(posedge clk) begin
    if (fill) begin
      tags[index] <= tag;
    end
    if (rd) begin
      tag_q <= tags[index];
    end
  end

  assign hit = valid_q & (tag_q == tag);

endmodule

`default_nettype wire

/* hdl/dcache_data_array.sv */
// Line store with byte-lane writes, refill shift register and
// read word selection for the core
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array
  import dcache_pkg::*;
(
  input  logic               clk,
  input  logic               rstn,
  input  logic [INDEX_W-1:0] index,
  input  logic [1:0]         word_sel,
  input  access_size_e       size,
  input  logic [1:0]         byte_off,
  input  logic [DATA_W-1:0]  wdata,
  input  logic               rd,
  input  logic               fill_shift,
  input  logic               fill_write,
  input  logic               word_write,
  input  logic [DATA_W-1:0]  fill_word,
  output logic [DATA_W-1:0]  rdata
);

  localparam int LINE_BYTES = LINE_W / 8;

  logic [LINE_W-1:0]     mem [NUM_LINES];
  logic [LINE_W-1:0]     line_q;
  logic [LINE_W-1:0]     shift_q;
  logic [LINE_W-1:0]     src_line;
  logic                  use_shift_q;
  logic [3:0]            word_be;
  logic [LINE_BYTES-1:0] line_be;
  logic [DATA_W-1:0]     lanes;

  // ========================================
  // Write enables for a store hit
  // ========================================
  assign word_be = byte_sel(size, byte_off);
  assign line_be = LINE_BYTES'(word_be) << {word_sel, 2'b00};
  assign lanes   = lane_data(size, wdata);

  always_ff @(posedge clk) begin
    if (fill_write) begin
      mem[index] <= shift_q;
    end else if (word_write) begin
      for (int i = 0; i < LINE_BYTES; i++) begin
        if (line_be[i]) begin
          mem[index][i*8 +: 8] <= lanes[(i % 4)*8 +: 8];
        end
      end
    end
  end

  // ========================================
  // Read path and refill assembly
  // ========================================
  always_ff @(posedge clk) begin
    if (rd) begin
      line_q <= mem[index];
    end
    // Beats arrive lowest word first, so shift in from the top
    if (fill_shift) begin
      shift_q <= {fill_word, shift_q[LINE_W-1:DATA_W]};
    end
  end

  // Refilled line is served from the shift register until the next read
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      use_shift_q <= 1'b0;
    end else if (rd) begin
      use_shift_q <= 1'b0;
    end else if (fill_shift) begin
      use_shift_q <= 1'b1;
    end
  end

  assign src_line = use_shift_q ? shift_q : line_q;
  assign rdata    = src_line[word_sel*DATA_W +: DATA_W];

endmodule

`default_nettype wire

/* hdl/dcache_top.sv */
// Top level of the direct-mapped write-through data cache
// Core request/wait port on one side, Wishbone classic master on the other
`timescale 1ns/1ps
`default_nettype none

module dcache_top
  import dcache_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  input  logic              core_valid,
  input  core_req_t         core_in,
  input  wb_rsp_t           wb_rsp,
  output logic              core_wait,
  output logic [DATA_W-1:0] core_rdata,
  output wb_req_t           wb_req,
  output logic [31:0]       rd_hits,
  output logic [31:0]       wr_hits,
  output logic [31:0]       rd_misses,
  output logic [31:0]       wr_misses
);

  core_req_t          req_q;
  dcache_state_e      state;
  logic               hit;
  logic               last_beat;
  logic [1:0]         beat_addr;
  logic               tag_rd;
  logic               tag_fill;
  logic               data_rd;
  logic               data_fill_shift;
  logic               data_fill_write;
  logic               data_word_write;
  logic               beat_clear;
  logic               beat_inc;
  logic [INDEX_W-1:0] index;

  // Live index while idle, sampled index afterwards
  assign index = (state == IDLE) ? core_in.addr[OFFSET_W +: INDEX_W]
                                 : req_q.addr[OFFSET_W +: INDEX_W];

  dcache_ctrl ctrl_inst (
    .clk             (clk),
    .rstn            (rstn),
    .core_valid      (core_valid),
    .core_in         (core_in),
    .wb_rsp          (wb_rsp),
    .hit             (hit),
    .last_beat       (last_beat),
    .beat_addr       (beat_addr),
    .core_wait       (core_wait),
    .req_q           (req_q),
    .wb_req          (wb_req),
    .state           (state),
    .tag_rd          (tag_rd),
    .tag_fill        (tag_fill),
    .data_rd         (data_rd),
    .data_fill_shift (data_fill_shift),
    .data_fill_write (data_fill_write),
    .data_word_write (data_word_write),
    .beat_clear      (beat_clear),
    .beat_inc        (beat_inc)
  );

  dcache_counters counters_inst (
    .clk        (clk),
    .rstn       (rstn),
    .state      (state),
    .hit        (hit),
    .beat_clear (beat_clear),
    .beat_inc   (beat_inc),
    .is_write   (req_q.write),
    .beat_addr  (beat_addr),
    .last_beat  (last_beat),
    .rd_hits    (rd_hits),
    .wr_hits    (wr_hits),
    .rd_misses  (rd_misses),
    .wr_misses  (wr_misses)
  );

  dcache_tag_array tag_array_inst (
    .clk   (clk),
    .rstn  (rstn),
    .index (index),
    .tag   (req_q.addr[ADDR_W-1 -: TAG_W]),
    .rd    (tag_rd),
    .fill  (tag_fill),
    .hit   (hit)
  );

  dcache_data_array data_array_inst (
    .clk        (clk),
    .rstn       (rstn),
    .index      (index),
    .word_sel   (req_q.addr[OFFSET_W-1:2]),
    .size       (req_q.size),
    .byte_off   (req_q.addr[1:0]),
    .wdata      (req_q.wdata),
    .rd         (data_rd),
    .fill_shift (data_fill_shift),
    .fill_write (data_fill_write),
    .word_write (data_word_write),
    .fill_word  (wb_rsp.dat),
    .rdata      (core_rdata)
  );

endmodule

`default_nettype wire

/* test/wb_mem_model.sv */
// Wishbone classic slave memory for the cache testbench
// Unwritten words read as an address-derived pattern, ack delay is random
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model
  import dcache_pkg::*;
(
  input  logic    clk,
  input  logic    rstn,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp
);

  logic [31:0] mem [logic [29:0]];
  integer      seed = 55;
  int          delay;

  function automatic logic [31:0] fill_pattern(logic [29:0] wa);
    return ({wa, 2'b10} * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  function automatic logic [31:0] word_at(logic [29:0] wa);
    if (mem.exists(wa)) begin
      return mem[wa];
    end
    return fill_pattern(wa);
  endfunction

  task automatic store_word(logic [29:0] wa, logic [3:0] sel, logic [31:0] dat);
    logic [31:0] word;
    word = word_at(wa);
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        word[b*8 +: 8] = dat[b*8 +: 8];
      end
    end
    mem[wa] = word;
  endtask

  // Registered ack, 0 to 3 extra wait cycles per beat
  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wb_rsp <= '0;
      delay  <= 0;
    end else if (wb_rsp.ack) begin
      wb_rsp.ack <= 1'b0;
      delay      <= $random(seed) & 3;
    end else if (wb_req.cyc && wb_req.stb) begin
      if (delay == 0) begin
        wb_rsp.ack <= 1'b1;
        if (wb_req.we) begin
          store_word(wb_req.adr[31:2], wb_req.sel, wb_req.dat);
        end else begin
          wb_rsp.dat <= word_at(wb_req.adr[31:2]);
        end
      end else begin
        delay <= delay - 1;
      end
    end
  end

endmodule

`default_nettype wire

/* test/dcache_top_sva.sv */
// Assertions bound into the cache top level
// Wishbone beat stability and the core wait handshake
`timescale 1ns/1ps
`default_nettype none

module dcache_top_sva
  import dcache_pkg::*;
(
  input logic          clk,
  input logic          rstn,
  input logic          core_valid,
  input wb_req_t       wb_req,
  input wb_rsp_t       wb_rsp,
  input logic          core_wait,
  input dcache_state_e state
);

  // Cycle only ends after the slave acked, and stb goes down with cyc
  cyc_drops_after_ack: assert property (
    @(posedge clk) disable iff (!rstn)
    $fell(wb_req.cyc) |-> ($past(wb_rsp.ack) && !wb_req.stb)
  ) else $error("Wishbone cycle ended without an ack");

  // Beat held unchanged until the slave acks
  beat_held_until_ack: assert property (
    @(posedge clk) disable iff (!rstn)
    (wb_req.stb && !wb_rsp.ack) |=> (wb_req.stb && $stable(wb_req.adr) &&
      $stable(wb_req.we) && $stable(wb_req.sel) && $stable(wb_req.dat))
  ) else $error("Wishbone request changed before ack");

  // Idle cache only raises core_wait for a request it accepted
  idle_wait_follows_valid: assert property (
    @(posedge clk) disable iff (!rstn)
    (state == IDLE) |=> (core_wait == $past(core_valid))
  ) else $error("core_wait out of step with the request seen while idle");

endmodule

`default_nettype wire

/* test/tb_dcache_top.sv */
// Directed testbench for the data cache against a shadow memory
// Covers refill, hits, sized write-through, write miss, conflict and counters
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_top
  import dcache_pkg::*;
();

  // Twice 30 accesses of up to 30 cycles plus reset margin
  localparam int MAX_ACCESSES      = 30;
  localparam int MAX_ACCESS_CYCLES = 30;
  localparam int TIMEOUT_CYCLES    = 2 * MAX_ACCESSES * MAX_ACCESS_CYCLES + 200;

  logic        clk;
  logic        rstn;
  logic        core_valid;
  core_req_t   core_in;
  logic        core_wait;
  logic [31:0] core_rdata;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic [31:0] rd_hits;
  logic [31:0] wr_hits;
  logic [31:0] rd_misses;
  logic [31:0] wr_misses;

  // Shadow memory and predicted tag state
  logic [31:0]          shadow [logic [29:0]];
  logic [TAG_W-1:0]     tag_model [NUM_LINES];
  logic [NUM_LINES-1:0] valid_model;
  wb_req_t              bus_log [$];
  int                   exp_rd_hits = 0;
  int                   exp_wr_hits = 0;
  int                   exp_rd_misses = 0;
  int                   exp_wr_misses = 0;
  int                   cycle_count = 0;
  logic                 error_seen = 1'b0;

  dcache_top dcache_top_inst (
    .clk        (clk),
    .rstn       (rstn),
    .core_valid (core_valid),
    .core_in    (core_in),
    .wb_rsp     (wb_rsp),
    .core_wait  (core_wait),
    .core_rdata (core_rdata),
    .wb_req     (wb_req),
    .rd_hits    (rd_hits),
    .wr_hits    (wr_hits),
    .rd_misses  (rd_misses),
    .wr_misses  (wr_misses)
  );

  wb_mem_model mem_inst (
    .clk    (clk),
    .rstn   (rstn),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  bind dcache_top dcache_top_sva sva_inst (
    .clk        (clk),
    .rstn       (rstn),
    .core_valid (core_valid),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .core_wait  (core_wait),
    .state      (state)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // ========================================
  // Checking helpers
  // ========================================
  task automatic abort_run(string why);
    error_seen = 1'b1;
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic compare_value(string name, logic [31:0] exp, logic [31:0] got);
    assert (got == exp) else begin
      abort_run($sformatf("ERR t=%0t %s exp=%h got=%h", $time, name, exp, got));
    end
  endtask

  task automatic require_true(logic cond, string what);
    assert (cond) else begin
      abort_run(what);
    end
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout after %0d cycles, tests did not finish", cycle_count));
    end
  end

  // Completed beats sampled mid-cycle while ack is stable
  always @(negedge clk) begin
    if (wb_req.cyc && wb_req.stb && wb_rsp.ack) begin
      bus_log.push_back(wb_req);
    end
  end

  function automatic logic [31:0] fill_pattern(logic [29:0] wa);
    return ({wa, 2'b10} * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  function automatic logic [31:0] shadow_word(logic [29:0] wa);
    if (shadow.exists(wa)) begin
      return shadow[wa];
    end
    return fill_pattern(wa);
  endfunction

  // Lanes covered by an aligned access of the given size
  function automatic logic [3:0] lane_select(access_size_e sz, logic [1:0] off);
    logic [3:0] sel;
    int         nbytes;
    nbytes = (sz == SIZE_BYTE) ? 1 : (sz == SIZE_HALF) ? 2 : 4;
    for (int b = 0; b < 4; b++) begin
      sel[b] = (b >= int'(off)) && (b < int'(off) + nbytes);
    end
    return sel;
  endfunction

  // ========================================
  // One core access with full response check
  // ========================================
  task automatic cache_access(logic wr, access_size_e sz, logic [31:0] addr,
                              logic [31:0] wd, logic want_hit);
    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   tag;
    logic [29:0]        wa;
    logic [3:0]         sel;
    logic [31:0]        merged;
    logic               pred_hit;
    int                 wait_cycles;
    int                 src;
    idx      = addr[OFFSET_W +: INDEX_W];
    tag      = addr[ADDR_W-1 -: TAG_W];
    wa       = addr[31:2];
    pred_hit = valid_model[idx] && (tag_model[idx] == tag);
    require_true(pred_hit == want_hit,
                 $sformatf("Access at %h does not classify as the test intends", addr));
    bus_log.delete();
    core_in.write = wr;
    core_in.size  = sz;
    core_in.addr  = addr;
    core_in.wdata = wd;
    core_valid    = 1'b1;
    @(posedge clk);
    #1;
    wait_cycles = 0;
    while (core_wait) begin
      wait_cycles++;
      @(posedge clk);
      #1;
    end
    core_valid = 1'b0;
    require_true(wait_cycles > 0, $sformatf("Request at %h was never accepted", addr));
    if (!wr) begin
      compare_value("core_rdata", shadow_word(wa), core_rdata);
      if (pred_hit) begin
        compare_value("core_wait cycles", 32'd1, 32'(wait_cycles));
        compare_value("wb beats on hit", 32'd0, 32'(bus_log.size()));
        exp_rd_hits++;
      end else begin
        compare_value("refill beats", 32'd4, 32'(bus_log.size()));
        for (int i = 0; i < bus_log.size(); i++) begin
          compare_value("wb_req.adr", {addr[31:4], 4'b0000} + 32'(4 * i), bus_log[i].adr);
          compare_value("wb_req.we", 32'd0, 32'(bus_log[i].we));
          compare_value("wb_req.sel", 32'hf, 32'(bus_log[i].sel));
        end
        tag_model[idx]   = tag;
        valid_model[idx] = 1'b1;
        exp_rd_misses++;
      end
    end else begin
      sel    = lane_select(sz, addr[1:0]);
      merged = shadow_word(wa);
      compare_value("write beats", 32'd1, 32'(bus_log.size()));
      compare_value("wb_req.adr", {addr[31:2], 2'b00}, bus_log[0].adr);
      compare_value("wb_req.we", 32'd1, 32'(bus_log[0].we));
      compare_value("wb_req.sel", 32'(sel), 32'(bus_log[0].sel));
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) begin
          src = b - int'(addr[1:0]);
          compare_value($sformatf("wb_req.dat lane %0d", b), 32'(wd[src*8 +: 8]),
                        32'(bus_log[0].dat[b*8 +: 8]));
          merged[b*8 +: 8] = wd[src*8 +: 8];
        end
      end
      shadow[wa] = merged;
      if (pred_hit) begin
        exp_wr_hits++;
      end else begin
        exp_wr_misses++;
      end
    end
  endtask

  // ========================================
  // Directed tests
  // ========================================
  task automatic read_miss_refill();
    cache_access(1'b0, SIZE_WORD, 32'h0000_1048, 32'h0, 1'b0);
    cache_access(1'b0, SIZE_WORD, 32'h0000_2384, 32'h0, 1'b0);
  endtask

  task automatic read_hit_reuse();
    for (int w = 0; w < LINE_WORDS; w++) begin
      cache_access(1'b0, SIZE_WORD, 32'h0000_1040 + 32'(4 * w), 32'h0, 1'b1);
    end
  endtask

  task automatic write_hit_sizes();
    cache_access(1'b1, SIZE_BYTE, 32'h0000_1041, 32'h0000_00a5, 1'b1);
    cache_access(1'b1, SIZE_BYTE, 32'h0000_1043, 32'h0000_003c, 1'b1);
    cache_access(1'b1, SIZE_HALF, 32'h0000_1046, 32'h0000_beef, 1'b1);
    cache_access(1'b1, SIZE_HALF, 32'h0000_1048, 32'h0000_1234, 1'b1);
    cache_access(1'b1, SIZE_WORD, 32'h0000_104c, 32'hcafe_f00d, 1'b1);
    for (int w = 0; w < LINE_WORDS; w++) begin
      cache_access(1'b0, SIZE_WORD, 32'h0000_1040 + 32'(4 * w), 32'h0, 1'b1);
    end
  endtask

  task automatic write_miss_no_alloc();
    cache_access(1'b1, SIZE_WORD, 32'h0000_3050, 32'h1357_9bdf, 1'b0);
    cache_access(1'b0, SIZE_WORD, 32'h0000_3050, 32'h0, 1'b0);
    cache_access(1'b0, SIZE_WORD, 32'h0000_3054, 32'h0, 1'b1);
    cache_access(1'b1, SIZE_HALF, 32'h0000_3066, 32'h0000_7e81, 1'b0);
    cache_access(1'b0, SIZE_WORD, 32'h0000_3064, 32'h0, 1'b0);
  endtask

  // Same index 4, different tag
  task automatic tag_conflict();
    cache_access(1'b0, SIZE_WORD, 32'h0005_1044, 32'h0, 1'b0);
    cache_access(1'b0, SIZE_WORD, 32'h0000_1040, 32'h0, 1'b0);
    cache_access(1'b0, SIZE_WORD, 32'h0000_104c, 32'h0, 1'b1);
    cache_access(1'b0, SIZE_WORD, 32'h0005_1040, 32'h0, 1'b0);
  endtask

  task automatic counter_totals();
    compare_value("rd_hits", 32'(exp_rd_hits), rd_hits);
    compare_value("wr_hits", 32'(exp_wr_hits), wr_hits);
    compare_value("rd_misses", 32'(exp_rd_misses), rd_misses);
    compare_value("wr_misses", 32'(exp_wr_misses), wr_misses);
  endtask

  initial begin
    rstn        = 1'b0;
    core_valid  = 1'b0;
    core_in     = '0;
    valid_model = '0;
    repeat (4) @(posedge clk);
    #1;
    rstn = 1'b1;
    read_miss_refill();
    read_hit_reuse();
    write_hit_sizes();
    write_miss_no_alloc();
    tag_conflict();
    counter_totals();
    if (!error_seen) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dcache_top.f */
hdl/dcache_pkg.sv
hdl/dcache_ctrl.sv
hdl/dcache_counters.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_array.sv
hdl/dcache_top.sv
test/wb_mem_model.sv
test/dcache_top_sva.sv
test/tb_dcache_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dcache_top
FILELIST  ?= dcache_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
